//--- design/core_pkg.sv
// core package
// shared widths, kept RISC-V opcodes and function fields, and the ALU
// operation encoding for the in-order integer pipeline
package core_pkg;

  // data and address widths
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [31:0] pc_t;
  typedef logic [4:0]  reg_index_t;

  localparam int NUM_REGS = 32;

  // major opcodes that are decoded
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

  // funct3 values shared by OP and OP-IMM
  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  // funct7 selects SUB and SRA against the base operation
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  // ALU operation carried from issue into the ALU pipe
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLTU   = 4'd6,
    ALU_SLL    = 4'd7,
    ALU_SRL    = 4'd8,
    ALU_SRA    = 4'd9,
    // LUI passes the immediate straight through
    ALU_PASS_B = 4'd10
  } alu_op_e;

endpackage

//--- design/fetch_buffer.sv
// fetch buffer
// circular FIFO of instruction word and PC pairs between the fetcher and
// the issue stage; writes arriving while full are dropped
module fetch_buffer
  import core_pkg::*;
#(
  parameter int FB_DEPTH = 4
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  write_strobe,
  input  inst_t write_word,
  input  pc_t   write_pc,
  input  logic  pop,
  output logic  head_valid,
  output inst_t head_word,
  output pc_t   head_pc,
  output logic  full
);

  localparam int PTR_W = $clog2(FB_DEPTH);

  inst_t            word_mem [FB_DEPTH];
  pc_t              pc_mem   [FB_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             take;

  assign full       = (count == (PTR_W + 1)'(FB_DEPTH));
  assign head_valid = (count != '0);
  assign head_word  = word_mem[rd_ptr];
  assign head_pc    = pc_mem[rd_ptr];

  assign push = write_strobe && !full;
  assign take = pop && head_valid;

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (take) rd_ptr <= rd_ptr + 1'b1;
      if (push && !take) count <= count + 1'b1;
      else if (take && !push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      word_mem[wr_ptr] <= write_word;
      pc_mem[wr_ptr]   <= write_pc;
    end
  end

endmodule

//--- design/inst_decode.sv
// instruction decode
// combinational decode of the buffer head into register indices,
// immediate, source usage and ALU operation
module inst_decode
  import core_pkg::*;
(
  input  inst_t      word,
  output logic       legal,
  output reg_index_t rs1,
  output reg_index_t rs2,
  output reg_index_t rd,
  output logic       uses_rs1,
  output logic       uses_rs2,
  output logic       use_imm,
  output xlen_t      imm,
  output alu_op_e    alu_op
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       base;
  logic       alt;

  assign opcode = word[6:0];
  assign funct3 = word[14:12];
  assign funct7 = word[31:25];
  assign rs1    = word[19:15];
  assign rs2    = word[24:20];
  assign rd     = word[11:7];
  assign base   = (funct7 == FUNCT7_BASE);
  assign alt    = (funct7 == FUNCT7_ALT);

  always_comb begin
    legal    = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    use_imm  = 1'b0;
    imm      = {{20{word[31]}}, word[31:20]};
    alu_op   = ALU_ADD;
    case (opcode)
      OPCODE_OP: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        case (funct3)
          FUNCT3_ADD_SUB: begin
            legal  = base || alt;
            alu_op = alt ? ALU_SUB : ALU_ADD;
          end
          FUNCT3_SRL_SRA: begin
            legal  = base || alt;
            alu_op = alt ? ALU_SRA : ALU_SRL;
          end
          FUNCT3_SLL:  begin legal = base; alu_op = ALU_SLL;  end
          FUNCT3_SLT:  begin legal = base; alu_op = ALU_SLT;  end
          FUNCT3_SLTU: begin legal = base; alu_op = ALU_SLTU; end
          FUNCT3_XOR:  begin legal = base; alu_op = ALU_XOR;  end
          FUNCT3_OR:   begin legal = base; alu_op = ALU_OR;   end
          default:     begin legal = base; alu_op = ALU_AND;  end
        endcase
      end
      OPCODE_OP_IMM: begin
        uses_rs1 = 1'b1;
        use_imm  = 1'b1;
        legal    = 1'b1;
        case (funct3)
          FUNCT3_ADD_SUB: alu_op = ALU_ADD;
          FUNCT3_SLT:     alu_op = ALU_SLT;
          FUNCT3_SLTU:    alu_op = ALU_SLTU;
          FUNCT3_XOR:     alu_op = ALU_XOR;
          FUNCT3_OR:      alu_op = ALU_OR;
          FUNCT3_AND:     alu_op = ALU_AND;
          FUNCT3_SLL: begin
            legal  = base;
            alu_op = ALU_SLL;
            imm    = {27'b0, word[24:20]};
          end
          default: begin
            // shift right immediate, funct7 picks logical or arithmetic
            legal  = base || alt;
            alu_op = alt ? ALU_SRA : ALU_SRL;
            imm    = {27'b0, word[24:20]};
          end
        endcase
      end
      OPCODE_LUI: begin
        legal   = 1'b1;
        use_imm = 1'b1;
        imm     = {word[31:12], 12'b0};
        alu_op  = ALU_PASS_B;
      end
      default: legal = 1'b0;
    endcase
  end

endmodule

//--- design/scoreboard.sv
// register scoreboard
// one busy bit per architectural register, set when a writer issues
// and cleared when its result is written back
module scoreboard
  import core_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       set_strobe,
  input  reg_index_t set_index,
  input  logic       clear_strobe,
  input  reg_index_t clear_index,
  input  reg_index_t rs1,
  input  reg_index_t rs2,
  output logic       rs1_busy,
  output logic       rs2_busy
);

  logic [NUM_REGS-1:0] busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (clear_strobe) busy[clear_index] <= 1'b0;
      // a new writer keeps the bit even if the old one retires now
      if (set_strobe) busy[set_index] <= 1'b1;
    end
  end

  assign rs1_busy = busy[rs1];
  assign rs2_busy = busy[rs2];

endmodule

//--- design/register_file.sv
// integer register file
// 32 x 32-bit, two combinational read ports and one write port,
// x0 is never written so it always reads zero
module register_file
  import core_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  reg_index_t rs1,
  input  reg_index_t rs2,
  input  logic       write_strobe,
  input  reg_index_t write_index,
  input  xlen_t      write_data,
  output xlen_t      rs1_data,
  output xlen_t      rs2_data
);

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_strobe && (write_index != '0)) begin
      regs[write_index] <= write_data;
    end
  end

  // no bypass, a write shows up on the following cycle
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

//--- design/issue_stage.sv
// issue stage
// decodes the buffer head, checks the scoreboard, reads operands and
// loads the execute pipeline register; illegal words are popped and reported
module issue_stage
  import core_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       head_valid,
  input  inst_t      head_word,
  input  pc_t        head_pc,
  input  logic       rs1_busy,
  input  logic       rs2_busy,
  input  xlen_t      rs1_data,
  input  xlen_t      rs2_data,
  output logic       pop,
  output reg_index_t rs1,
  output reg_index_t rs2,
  output logic       set_strobe,
  output reg_index_t set_index,
  output logic       ex_valid,
  output alu_op_e    ex_op,
  output xlen_t      ex_a,
  output xlen_t      ex_b,
  output reg_index_t ex_rd,
  output pc_t        ex_pc,
  output logic       illegal_strobe,
  output pc_t        illegal_pc
);

  logic       legal;
  reg_index_t rd;
  logic       uses_rs1;
  logic       uses_rs2;
  logic       use_imm;
  xlen_t      imm;
  alu_op_e    alu_op;
  logic       src_ready;
  logic       waw_hazard;
  logic       issue;
  logic       reject;
  logic       writes_rd;

  inst_decode i_inst_decode (
    .word     (head_word),
    .legal    (legal),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .uses_rs1 (uses_rs1),
    .uses_rs2 (uses_rs2),
    .use_imm  (use_imm),
    .imm      (imm),
    .alu_op   (alu_op)
  );

  assign src_ready = !(uses_rs1 && rs1_busy) && !(uses_rs2 && rs2_busy);
  // same rd still in execute would have its busy bit cleared too early
  assign waw_hazard = ex_valid && (ex_rd == rd);
  assign writes_rd  = (rd != '0);

  assign issue      = head_valid && legal && src_ready && !waw_hazard;
  assign reject     = head_valid && !legal;
  assign pop        = issue || reject;
  assign set_strobe = issue && writes_rd;
  assign set_index  = rd;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid       <= 1'b0;
      illegal_strobe <= 1'b0;
    end else begin
      ex_valid       <= issue && writes_rd;
      illegal_strobe <= reject;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      ex_op <= alu_op;
      ex_a  <= rs1_data;
      ex_b  <= use_imm ? imm : rs2_data;
      ex_rd <= rd;
      ex_pc <= head_pc;
    end
    if (reject) illegal_pc <= head_pc;
  end

endmodule

//--- design/alu_pipe.sv
// ALU pipe
// single-cycle RISC-V integer ALU followed by the writeback register
module alu_pipe
  import core_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       ex_valid,
  input  alu_op_e    ex_op,
  input  xlen_t      ex_a,
  input  xlen_t      ex_b,
  input  reg_index_t ex_rd,
  input  pc_t        ex_pc,
  output logic       wb_strobe,
  output reg_index_t wb_rd,
  output xlen_t      wb_data,
  output pc_t        wb_pc
);

  xlen_t      result;
  logic [4:0] shamt;

  // shifts only look at the low five bits
  assign shamt = ex_b[4:0];

  always_comb begin
    case (ex_op)
      ALU_ADD:    result = ex_a + ex_b;
      ALU_SUB:    result = ex_a - ex_b;
      ALU_AND:    result = ex_a & ex_b;
      ALU_OR:     result = ex_a | ex_b;
      ALU_XOR:    result = ex_a ^ ex_b;
      ALU_SLT:    result = {31'b0, ($signed(ex_a) < $signed(ex_b))};
      ALU_SLTU:   result = {31'b0, (ex_a < ex_b)};
      ALU_SLL:    result = ex_a << shamt;
      ALU_SRL:    result = ex_a >> shamt;
      ALU_SRA:    result = $signed(ex_a) >>> shamt;
      ALU_PASS_B: result = ex_b;
      default:    result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) wb_strobe <= 1'b0;
    else wb_strobe <= ex_valid;
  end

  always_ff @(posedge clock) begin
    if (ex_valid) begin
      wb_rd   <= ex_rd;
      wb_data <= result;
      wb_pc   <= ex_pc;
    end
  end

endmodule

//--- design/core.sv
// integer core top level
// fetch buffer, issue with scoreboard and register file, and one ALU pipe
module core
  import core_pkg::*;
#(
  parameter int FB_DEPTH = 4
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       inst_strobe,
  input  inst_t      inst_word,
  input  pc_t        inst_pc,
  output logic       fb_full,
  output logic       wb_strobe,
  output reg_index_t wb_rd,
  output xlen_t      wb_data,
  output pc_t        wb_pc,
  output logic       illegal_strobe,
  output pc_t        illegal_pc
);

  logic       head_valid;
  inst_t      head_word;
  pc_t        head_pc;
  logic       pop;
  reg_index_t rs1;
  reg_index_t rs2;
  logic       rs1_busy;
  logic       rs2_busy;
  xlen_t      rs1_data;
  xlen_t      rs2_data;
  logic       set_strobe;
  reg_index_t set_index;
  logic       ex_valid;
  alu_op_e    ex_op;
  xlen_t      ex_a;
  xlen_t      ex_b;
  reg_index_t ex_rd;
  pc_t        ex_pc;

  fetch_buffer #(
    .FB_DEPTH (FB_DEPTH)
  ) i_fetch_buffer (
    .clock        (clock),
    .reset        (reset),
    .write_strobe (inst_strobe),
    .write_word   (inst_word),
    .write_pc     (inst_pc),
    .pop          (pop),
    .head_valid   (head_valid),
    .head_word    (head_word),
    .head_pc      (head_pc),
    .full         (fb_full)
  );

  issue_stage i_issue_stage (
    .clock          (clock),
    .reset          (reset),
    .head_valid     (head_valid),
    .head_word      (head_word),
    .head_pc        (head_pc),
    .rs1_busy       (rs1_busy),
    .rs2_busy       (rs2_busy),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .pop            (pop),
    .rs1            (rs1),
    .rs2            (rs2),
    .set_strobe     (set_strobe),
    .set_index      (set_index),
    .ex_valid       (ex_valid),
    .ex_op          (ex_op),
    .ex_a           (ex_a),
    .ex_b           (ex_b),
    .ex_rd          (ex_rd),
    .ex_pc          (ex_pc),
    .illegal_strobe (illegal_strobe),
    .illegal_pc     (illegal_pc)
  );

  // writeback clears the busy bit and writes the register file
  scoreboard i_scoreboard (
    .clock        (clock),
    .reset        (reset),
    .set_strobe   (set_strobe),
    .set_index    (set_index),
    .clear_strobe (wb_strobe),
    .clear_index  (wb_rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .rs1_busy     (rs1_busy),
    .rs2_busy     (rs2_busy)
  );

  register_file i_register_file (
    .clock        (clock),
    .reset        (reset),
    .rs1          (rs1),
    .rs2          (rs2),
    .write_strobe (wb_strobe),
    .write_index  (wb_rd),
    .write_data   (wb_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  alu_pipe i_alu_pipe (
    .clock     (clock),
    .reset     (reset),
    .ex_valid  (ex_valid),
    .ex_op     (ex_op),
    .ex_a      (ex_a),
    .ex_b      (ex_b),
    .ex_rd     (ex_rd),
    .ex_pc     (ex_pc),
    .wb_strobe (wb_strobe),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .wb_pc     (wb_pc)
  );

endmodule

//--- tests/core_tb.sv
// core testbench
// directed tests against a register-array reference model, with a
// writeback monitor, illegal report checks and a cycle timeout
module core_tb
  import core_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 20000;

  logic clock = 1'b0;
  logic reset = 1'b1;
  logic inst_strobe = 1'b0;
  inst_t inst_word = '0;
  pc_t inst_pc = '0;
  logic fb_full;
  logic wb_strobe;
  reg_index_t wb_rd;
  xlen_t wb_data;
  pc_t wb_pc;
  logic illegal_strobe;
  pc_t illegal_pc;

  xlen_t model_regs [NUM_REGS];
  reg_index_t exp_rd [$];
  xlen_t exp_data [$];
  pc_t exp_pc [$];
  pc_t exp_illegal [$];
  pc_t next_pc = 32'h0000_1000;
  pc_t dropped_pc = '0;
  logic dropped_valid = 1'b0;
  string cur_test = "reset";
  int errors = 0;
  int test_start_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycles = 0;

  alu_op_e r_ops [10] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                          ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA};
  alu_op_e i_ops [9] = '{ALU_ADD, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
                         ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA};

  core #(
    .FB_DEPTH (4)
  ) i_core (
    .clock          (clock),
    .reset          (reset),
    .inst_strobe    (inst_strobe),
    .inst_word      (inst_word),
    .inst_pc        (inst_pc),
    .fb_full        (fb_full),
    .wb_strobe      (wb_strobe),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .wb_pc          (wb_pc),
    .illegal_strobe (illegal_strobe),
    .illegal_pc     (illegal_pc)
  );

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout in %s after %0d cycles, %0d writebacks and %0d illegal reports missing",
               cur_test, cycles, exp_rd.size(), exp_illegal.size());
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic compare_word(string label, xlen_t expected, xlen_t actual);
    if (expected !== actual) begin
      $display("Mismatch %s %s: expected %h actual %h", cur_test, label, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_reg(string label, reg_index_t expected, reg_index_t actual);
    if (expected !== actual) begin
      $display("Mismatch %s %s: expected %0d actual %0d", cur_test, label, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_pc(string label, pc_t expected, pc_t actual);
    if (expected !== actual) begin
      $display("Mismatch %s %s: expected %h actual %h", cur_test, label, expected, actual);
      errors++;
    end
  endtask

  // outputs are registered, so mid-cycle is a safe place to look
  always @(negedge clock) begin
    if (!reset && wb_strobe) begin
      if (dropped_valid && wb_pc == dropped_pc) begin
        $display("%s: instruction dropped while full wrote back at pc %h", cur_test, wb_pc);
        errors++;
      end
      if (exp_rd.size() == 0) begin
        $display("%s: unexpected writeback to x%0d at pc %h", cur_test, wb_rd, wb_pc);
        errors++;
      end else begin
        compare_reg("wb_rd", exp_rd.pop_front(), wb_rd);
        compare_word("wb_data", exp_data.pop_front(), wb_data);
        compare_pc("wb_pc", exp_pc.pop_front(), wb_pc);
      end
    end
    if (!reset && illegal_strobe) begin
      if (exp_illegal.size() == 0) begin
        $display("%s: unexpected illegal report at pc %h", cur_test, illegal_pc);
        errors++;
      end else begin
        compare_pc("illegal_pc", exp_illegal.pop_front(), illegal_pc);
      end
    end
  end

  // reference ALU from the RISC-V integer rules
  function automatic xlen_t model_alu(alu_op_e op, xlen_t a, xlen_t b);
    logic signed [31:0] sa;
    logic [4:0] shamt;
    sa = a;
    shamt = b[4:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_SLL:  return a << shamt;
      ALU_SRL:  return a >> shamt;
      ALU_SRA:  return sa >>> shamt;
      default:  return b;
    endcase
  endfunction

  function automatic logic [2:0] funct3_of(alu_op_e op);
    case (op)
      ALU_SLL:          return FUNCT3_SLL;
      ALU_SLT:          return FUNCT3_SLT;
      ALU_SLTU:         return FUNCT3_SLTU;
      ALU_XOR:          return FUNCT3_XOR;
      ALU_SRL, ALU_SRA: return FUNCT3_SRL_SRA;
      ALU_OR:           return FUNCT3_OR;
      ALU_AND:          return FUNCT3_AND;
      default:          return FUNCT3_ADD_SUB;
    endcase
  endfunction

  function automatic logic [6:0] funct7_of(alu_op_e op);
    return (op == ALU_SUB || op == ALU_SRA) ? FUNCT7_ALT : FUNCT7_BASE;
  endfunction

  // one strobe whatever fb_full says, returns 1 ns after the next edge
  task automatic drive_word(inst_t word);
    inst_strobe = 1'b1;
    inst_word = word;
    inst_pc = next_pc;
    next_pc += 4;
    @(posedge clock);
    #1;
    inst_strobe = 1'b0;
  endtask

  // called 1 ns after a rising edge, holds off while the buffer is full
  task automatic send_word(inst_t word);
    while (fb_full) begin
      @(posedge clock);
      #1;
    end
    drive_word(word);
  endtask

  task automatic expect_result(reg_index_t rd, xlen_t result);
    if (rd != '0) begin
      model_regs[rd] = result;
      exp_rd.push_back(rd);
      exp_data.push_back(result);
      exp_pc.push_back(next_pc);
    end
  endtask

  task automatic send_r(alu_op_e op, reg_index_t rd, reg_index_t rs1, reg_index_t rs2);
    expect_result(rd, model_alu(op, model_regs[rs1], model_regs[rs2]));
    send_word({funct7_of(op), rs2, rs1, funct3_of(op), rd, OPCODE_OP});
  endtask

  task automatic send_i(alu_op_e op, reg_index_t rd, reg_index_t rs1, logic [11:0] imm);
    logic [11:0] field;
    xlen_t b;
    if (op == ALU_SLL || op == ALU_SRL || op == ALU_SRA) begin
      field = {funct7_of(op), imm[4:0]};
      b = {27'b0, imm[4:0]};
    end else begin
      field = imm;
      b = {{20{imm[11]}}, imm};
    end
    expect_result(rd, model_alu(op, model_regs[rs1], b));
    send_word({field, rs1, funct3_of(op), rd, OPCODE_OP_IMM});
  endtask

  task automatic send_lui(reg_index_t rd, logic [19:0] upper);
    expect_result(rd, {upper, 12'b0});
    send_word({upper, rd, OPCODE_LUI});
  endtask

  task automatic wait_drain();
    while (exp_rd.size() != 0 || exp_illegal.size() != 0) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic begin_test(string name);
    cur_test = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    wait_drain();
    tests_run++;
    if (errors == test_start_errors) begin
      $display("%s: pass", cur_test);
    end else begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", cur_test, errors - test_start_errors);
    end
  endtask

  task automatic r_type_ops();
    begin_test("r_type_ops");
    send_i(ALU_ADD, 1, 0, -12'sd5);
    send_i(ALU_ADD, 2, 0, 12'd3);
    send_lui(3, 20'h80000);
    send_i(ALU_ADD, 4, 0, 12'd31);
    send_i(ALU_ADD, 5, 0, 12'hfff);
    send_r(ALU_ADD, 10, 1, 2);
    send_r(ALU_SUB, 11, 2, 1);
    send_r(ALU_AND, 12, 1, 3);
    send_r(ALU_OR, 13, 1, 3);
    send_r(ALU_XOR, 14, 1, 5);
    send_r(ALU_SLT, 15, 1, 2);
    send_r(ALU_SLTU, 16, 1, 2);
    send_r(ALU_SLT, 17, 3, 1);
    send_r(ALU_SLTU, 18, 3, 1);
    send_r(ALU_SLL, 19, 5, 4);
    send_r(ALU_SRL, 20, 3, 4);
    send_r(ALU_SRA, 21, 3, 4);
    send_r(ALU_SRA, 22, 1, 2);
    end_test();
  endtask

  task automatic immediate_ops();
    begin_test("immediate_ops");
    for (int r = 1; r < 8; r++) begin
      send_lui(r, 20'($urandom()));
      send_i(ALU_ADD, r, r, 12'($urandom()));
    end
    for (int round = 0; round < 3; round++) begin
      foreach (i_ops[k]) begin
        send_i(i_ops[k], 8 + $urandom_range(7, 0), 1 + $urandom_range(6, 0), 12'($urandom()));
      end
      send_lui(16 + $urandom_range(7, 0), 20'($urandom()));
    end
    end_test();
  endtask

  task automatic dependency_chain();
    reg_index_t prev;
    reg_index_t rd;
    begin_test("dependency_chain");
    send_i(ALU_ADD, 20, 0, 12'd7);
    prev = 20;
    for (int i = 0; i < 16; i++) begin
      rd = 21 + (i % 8);
      case (i % 4)
        0: send_r(ALU_ADD, rd, prev, prev);
        1: send_i(ALU_XOR, rd, prev, 12'($urandom()));
        2: send_r(ALU_SUB, rd, prev, 1);
        default: send_i(ALU_SLL, rd, prev, 12'd3);
      endcase
      prev = rd;
    end
    end_test();
  endtask

  task automatic buffer_full();
    int sent;
    begin_test("buffer_full");
    sent = 0;
    while (!fb_full && sent < 16) begin
      send_i(ALU_ADD, 9, 9, 12'd1);
      sent++;
    end
    if (!fb_full) begin
      $display("%s: fb_full never rose after %0d dependent sends", cur_test, sent);
      errors++;
    end
    // sent while full, so no model update and no expectation
    dropped_pc = next_pc;
    dropped_valid = 1'b1;
    drive_word({12'd100, 5'd9, FUNCT3_ADD_SUB, 5'd9, OPCODE_OP_IMM});
    send_r(ALU_ADD, 10, 9, 0);
    end_test();
  endtask

  task automatic illegal_and_x0();
    begin_test("illegal_and_x0");
    // a load word is not kept
    exp_illegal.push_back(next_pc);
    send_word({12'd0, 5'd1, 3'b010, 5'd3, 7'b0000011});
    send_i(ALU_ADD, 0, 2, 12'd5);
    send_r(ALU_ADD, 6, 0, 0);
    send_i(ALU_OR, 7, 0, 12'd0);
    end_test();
  endtask

  task automatic random_mix();
    int kind;
    begin_test("random_mix");
    for (int n = 0; n < 200; n++) begin
      repeat ($urandom_range(3, 0)) begin
        @(posedge clock);
        #1;
      end
      kind = $urandom_range(2, 0);
      if (kind == 0) begin
        send_r(r_ops[$urandom_range(9, 0)], 5'($urandom()), 5'($urandom()), 5'($urandom()));
      end else if (kind == 1) begin
        send_i(i_ops[$urandom_range(8, 0)], 5'($urandom()), 5'($urandom()), 12'($urandom()));
      end else begin
        send_lui(5'($urandom()), 20'($urandom()));
      end
    end
    end_test();
  endtask

  initial begin
    void'($urandom(54916));
    foreach (model_regs[i]) model_regs[i] = '0;
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b0;
    r_type_ops();
    immediate_ops();
    dependency_chain();
    buffer_full();
    illegal_and_x0();
    random_mix();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- build.f
design/core_pkg.sv
design/fetch_buffer.sv
design/inst_decode.sv
design/scoreboard.sv
design/register_file.sv
design/issue_stage.sv
design/alu_pipe.sv
design/core.sv
tests/core_tb.sv
